// File: design/aes_core_regs_pkg.sv
package aes_core_regs_pkg;

  typedef logic [7:0] reg_addr_t;

  // ---------------------------------------------------------
  // core register map
  // ---------------------------------------------------------
  localparam reg_addr_t ADDR_CTRL    = 8'h08;
  localparam reg_addr_t ADDR_STATUS  = 8'h09;
  localparam reg_addr_t ADDR_KEY0    = 8'h10;
  localparam reg_addr_t ADDR_BLOCK0  = 8'h20;
  localparam reg_addr_t ADDR_RESULT0 = 8'h30;

  // ctrl and status bits
  localparam int CTRL_INIT_BIT    = 0;
  localparam int CTRL_NEXT_BIT    = 1;
  localparam int STATUS_READY_BIT = 0;

  // extra cycles each write stays on the bus
  localparam int WRITE_HOLD_CYCLES = 2;

  typedef struct packed {
    logic        cs;
    logic        we;
    reg_addr_t   address;
    logic [31:0] write_data;
  } core_bus_req_t;

endpackage

// File: design/cbc_stream_pkg.sv
package cbc_stream_pkg;

  localparam int BLOCK_WORDS = 4;

  typedef logic [31:0]  word_t;
  typedef logic [127:0] block_t;
  typedef logic [1:0]   word_idx_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } axis_beat_t;

  // stream byte 0 sits in the top byte of a block word
  function automatic word_t word_bswap(word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // word 0 is the most significant word of the block
  function automatic word_t block_word(block_t b, word_idx_t idx);
    return b[(BLOCK_WORDS - 1 - int'(idx)) * 32 +: 32];
  endfunction

endpackage

// File: design/axis_block_gather.sv
`timescale 1ns/1ns

module axis_block_gather (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   enable,
  input  cbc_stream_pkg::word_t  tdata,
  input  logic                   tvalid,
  input  logic                   tlast,
  output logic                   tready,
  output cbc_stream_pkg::block_t block,
  output logic                   block_last,
  output logic                   block_valid
);

  import cbc_stream_pkg::*;

  word_idx_t word_cnt;
  logic      beat;

  // pause for one cycle while the finished block is handed over
  assign tready = enable && !block_valid;
  assign beat   = tvalid && tready;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      word_cnt    <= '0;
      block_valid <= 1'b0;
    end else begin
      block_valid <= beat && (word_cnt == word_idx_t'(BLOCK_WORDS - 1));
      if (beat) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // block payload
  always_ff @(posedge clk) begin
    if (beat) begin
      block[(BLOCK_WORDS - 1 - int'(word_cnt)) * 32 +: 32] <= word_bswap(tdata);
      if (word_cnt == word_idx_t'(BLOCK_WORDS - 1)) begin
        block_last <= tlast;
      end
    end
  end

endmodule

// File: design/cbc_chain_state.sv
`timescale 1ns/1ns

module cbc_chain_state (
  input  logic                       clk,
  input  logic                       load_iv,
  input  logic                       load_ct,
  input  logic                       advance_chain,
  input  cbc_stream_pkg::block_t     block,
  input  cbc_stream_pkg::word_idx_t  out_idx,
  input  cbc_stream_pkg::word_t      core_read_data,
  input  logic                       out_last,
  output cbc_stream_pkg::axis_beat_t pt_beat,
  output cbc_stream_pkg::block_t     cur_ct
);

  import cbc_stream_pkg::*;

  // iv_q xors the block now in the core
  // prev_ct_q is kept for the block after it
  block_t iv_q;
  block_t prev_ct_q;

  always_ff @(posedge clk) begin
    if (load_iv) begin
      // the iv acts as ciphertext block -1
      prev_ct_q <= block;
    end else if (advance_chain) begin
      iv_q      <= prev_ct_q;
      prev_ct_q <= cur_ct;
    end
    if (load_ct) begin
      cur_ct <= block;
    end
  end

  // ---------------------------------------------------------
  // plaintext word
  // ---------------------------------------------------------
  always_comb begin
    pt_beat.data = word_bswap(core_read_data ^ block_word(iv_q, out_idx));
    pt_beat.last = out_last;
  end

endmodule

// File: design/cbc_dec_sequencer.sv
`timescale 1ns/1ns

module cbc_dec_sequencer #(
  parameter int KE_WAIT_CYCLES  = 80,
  parameter int DEC_WAIT_CYCLES = 100
) (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          key_block_valid,
  input  logic                          payload_block_valid,
  input  logic                          payload_block_last,
  input  cbc_stream_pkg::block_t        key_block,
  input  cbc_stream_pkg::block_t        cur_ct,
  output logic                          key_enable,
  output logic                          payload_enable,
  output logic                          load_iv,
  output logic                          load_ct,
  output logic                          advance_chain,
  output aes_core_regs_pkg::core_bus_req_t core_req,
  input  cbc_stream_pkg::word_t         core_read_data,
  output cbc_stream_pkg::word_idx_t     out_idx,
  output logic                          out_valid,
  output logic                          out_last,
  input  logic                          out_ready
);

  import aes_core_regs_pkg::*;
  import cbc_stream_pkg::*;

  localparam int WAIT_MAX = (KE_WAIT_CYCLES > DEC_WAIT_CYCLES) ? KE_WAIT_CYCLES
                                                               : DEC_WAIT_CYCLES;
  localparam int WAIT_W   = $clog2(WAIT_MAX + 1);
  localparam int HOLD_W   = $clog2(WRITE_HOLD_CYCLES + 1);

  typedef enum logic [3:0] {
    S_KEY_COLLECT,
    S_KEY_LOAD,
    S_INIT,
    S_IV_COLLECT,
    S_CT_COLLECT,
    S_KE_WAIT,
    S_BLOCK_LOAD,
    S_NEXT,
    S_DEC_WAIT,
    S_OUTPUT
  } seq_state_t;

  seq_state_t        state;
  word_idx_t         word_idx;
  logic [HOLD_W-1:0] hold_cnt;
  logic [WAIT_W-1:0] wait_cnt;
  logic              ke_done;
  logic              last_flag;
  logic              write_done;
  logic              core_ready;
  logic              last_word;

  assign write_done = (hold_cnt == HOLD_W'(WRITE_HOLD_CYCLES));
  assign core_ready = core_read_data[STATUS_READY_BIT];
  assign last_word  = (word_idx == word_idx_t'(BLOCK_WORDS - 1));
  assign out_idx    = word_idx;

  // ---------------------------------------------------------
  // bus request and strobes, decoded from state
  // ---------------------------------------------------------
  always_comb begin
    core_req       = '0;
    key_enable     = 1'b0;
    payload_enable = 1'b0;
    load_iv        = 1'b0;
    load_ct        = 1'b0;
    advance_chain  = 1'b0;
    out_valid      = 1'b0;
    out_last       = 1'b0;
    case (state)
      S_KEY_COLLECT: key_enable = 1'b1;
      S_KEY_LOAD: begin
        core_req.cs         = 1'b1;
        core_req.we         = 1'b1;
        core_req.address    = ADDR_KEY0 + reg_addr_t'(word_idx);
        core_req.write_data = block_word(key_block, word_idx);
      end
      S_INIT: begin
        core_req.cs                        = 1'b1;
        core_req.we                        = 1'b1;
        core_req.address                   = ADDR_CTRL;
        core_req.write_data[CTRL_INIT_BIT] = 1'b1;
      end
      S_IV_COLLECT: begin
        payload_enable = 1'b1;
        load_iv        = payload_block_valid;
      end
      S_CT_COLLECT: begin
        payload_enable = 1'b1;
        load_ct        = payload_block_valid;
      end
      S_KE_WAIT, S_DEC_WAIT: begin
        core_req.cs      = 1'b1;
        core_req.address = ADDR_STATUS;
      end
      S_BLOCK_LOAD: begin
        core_req.cs         = 1'b1;
        core_req.we         = 1'b1;
        core_req.address    = ADDR_BLOCK0 + reg_addr_t'(word_idx);
        core_req.write_data = block_word(cur_ct, word_idx);
      end
      S_NEXT: begin
        core_req.cs                        = 1'b1;
        core_req.we                        = 1'b1;
        core_req.address                   = ADDR_CTRL;
        core_req.write_data[CTRL_NEXT_BIT] = 1'b1;
        advance_chain                      = write_done;
      end
      S_OUTPUT: begin
        core_req.cs      = 1'b1;
        core_req.address = ADDR_RESULT0 + reg_addr_t'(word_idx);
        // hold the word while the skid buffer is full
        out_valid        = out_ready;
        out_last         = last_flag && last_word;
      end
      default: ;
    endcase
  end

  // ---------------------------------------------------------
  // state and counters
  // ---------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= S_KEY_COLLECT;
      word_idx  <= '0;
      hold_cnt  <= '0;
      wait_cnt  <= '0;
      ke_done   <= 1'b0;
      last_flag <= 1'b0;
    end else begin
      // every write stays on the bus for a fixed count
      if (core_req.we) begin
        hold_cnt <= write_done ? '0 : hold_cnt + 1'b1;
      end
      case (state)
        S_KEY_COLLECT: begin
          if (key_block_valid) begin
            word_idx <= '0;
            state    <= S_KEY_LOAD;
          end
        end
        S_KEY_LOAD, S_BLOCK_LOAD: begin
          if (write_done) begin
            word_idx <= word_idx + 1'b1;
            if (last_word) begin
              state <= (state == S_KEY_LOAD) ? S_INIT : S_NEXT;
            end
          end
        end
        S_INIT: begin
          // key expansion runs in the core while the iv arrives
          if (write_done) begin
            wait_cnt <= '0;
            state    <= S_IV_COLLECT;
          end
        end
        S_IV_COLLECT: begin
          // key expansion wait counts from the init write
          if (!ke_done && wait_cnt != WAIT_W'(KE_WAIT_CYCLES)) begin
            wait_cnt <= wait_cnt + 1'b1;
          end
          if (payload_block_valid) begin
            state <= S_CT_COLLECT;
          end
        end
        S_CT_COLLECT: begin
          if (!ke_done && wait_cnt != WAIT_W'(KE_WAIT_CYCLES)) begin
            wait_cnt <= wait_cnt + 1'b1;
          end
          if (payload_block_valid) begin
            last_flag <= payload_block_last;
            word_idx  <= '0;
            state     <= ke_done ? S_BLOCK_LOAD : S_KE_WAIT;
          end
        end
        S_KE_WAIT: begin
          if (wait_cnt == WAIT_W'(KE_WAIT_CYCLES)) begin
            if (core_ready) begin
              ke_done <= 1'b1;
              state   <= S_BLOCK_LOAD;
            end
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        S_NEXT: begin
          if (write_done) begin
            wait_cnt <= '0;
            state    <= S_DEC_WAIT;
          end
        end
        S_DEC_WAIT: begin
          if (wait_cnt == WAIT_W'(DEC_WAIT_CYCLES)) begin
            if (core_ready) begin
              word_idx <= '0;
              state    <= S_OUTPUT;
            end
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        S_OUTPUT: begin
          if (out_ready) begin
            word_idx <= word_idx + 1'b1;
            if (last_word) begin
              // key stays loaded for the next payload
              state <= last_flag ? S_IV_COLLECT : S_CT_COLLECT;
            end
          end
        end
        default: state <= S_KEY_COLLECT;
      endcase
    end
  end

endmodule

// File: design/axis_out_skid.sv
`timescale 1ns/1ns

module axis_out_skid (
  input  logic                       clk,
  input  logic                       reset_n,
  input  cbc_stream_pkg::axis_beat_t in_beat,
  input  logic                       in_valid,
  output logic                       in_ready,
  output cbc_stream_pkg::axis_beat_t out_beat,
  output logic                       out_valid,
  input  logic                       out_ready
);

  import cbc_stream_pkg::*;

  axis_beat_t spare_beat;
  logic       spare_valid;
  logic       in_fire;
  logic       main_free;
  logic       main_from_spare;
  logic       main_from_in;
  logic       spare_from_in;

  assign in_ready  = !spare_valid;
  assign in_fire   = in_valid && in_ready;
  assign main_free = !out_valid || out_ready;

  // spare is older than any new input, so it drains first
  assign main_from_spare = main_free && spare_valid;
  assign main_from_in    = main_free && !spare_valid && in_fire;
  assign spare_from_in   = !main_free && in_fire;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end else begin
      if (main_free) begin
        out_valid   <= main_from_spare || main_from_in;
        spare_valid <= 1'b0;
      end else if (spare_from_in) begin
        spare_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (main_from_spare) begin
      out_beat <= spare_beat;
    end else if (main_from_in) begin
      out_beat <= in_beat;
    end
    if (spare_from_in) begin
      spare_beat <= in_beat;
    end
  end

endmodule

// File: design/aes_cbc_dec_top.sv
`timescale 1ns/1ns

module aes_cbc_dec_top #(
  parameter int KE_WAIT_CYCLES  = 80,
  parameter int DEC_WAIT_CYCLES = 100
) (
  input  logic                             clk,
  input  logic                             reset_n,
  input  cbc_stream_pkg::word_t            key_tdata,
  input  logic                             key_tvalid,
  output logic                             key_tready,
  input  cbc_stream_pkg::word_t            ct_tdata,
  input  logic                             ct_tvalid,
  input  logic                             ct_tlast,
  output logic                             ct_tready,
  output cbc_stream_pkg::word_t            pt_tdata,
  output logic                             pt_tvalid,
  output logic                             pt_tlast,
  input  logic                             pt_tready,
  output aes_core_regs_pkg::core_bus_req_t core_req,
  input  cbc_stream_pkg::word_t            core_read_data
);

  import cbc_stream_pkg::*;

  block_t     key_block;
  logic       key_block_valid;
  logic       key_enable;
  block_t     payload_block;
  logic       payload_block_valid;
  logic       payload_block_last;
  logic       payload_enable;
  logic       load_iv;
  logic       load_ct;
  logic       advance_chain;
  block_t     cur_ct;
  word_idx_t  out_idx;
  logic       seq_out_valid;
  logic       seq_out_last;
  logic       skid_in_ready;
  axis_beat_t pt_word;
  axis_beat_t pt_out;

  // key stream carries no last
  axis_block_gather key_gather (
    .clk(clk), .reset_n(reset_n), .enable(key_enable),
    .tdata(key_tdata), .tvalid(key_tvalid), .tlast(1'b0), .tready(key_tready),
    .block(key_block), .block_last(), .block_valid(key_block_valid)
  );

  axis_block_gather payload_gather (
    .clk(clk), .reset_n(reset_n), .enable(payload_enable),
    .tdata(ct_tdata), .tvalid(ct_tvalid), .tlast(ct_tlast), .tready(ct_tready),
    .block(payload_block), .block_last(payload_block_last),
    .block_valid(payload_block_valid)
  );

  cbc_dec_sequencer #(
    .KE_WAIT_CYCLES(KE_WAIT_CYCLES),
    .DEC_WAIT_CYCLES(DEC_WAIT_CYCLES)
  ) sequencer (
    .clk(clk), .reset_n(reset_n),
    .key_block_valid(key_block_valid), .payload_block_valid(payload_block_valid),
    .payload_block_last(payload_block_last), .key_block(key_block), .cur_ct(cur_ct),
    .key_enable(key_enable), .payload_enable(payload_enable),
    .load_iv(load_iv), .load_ct(load_ct), .advance_chain(advance_chain),
    .core_req(core_req), .core_read_data(core_read_data), .out_idx(out_idx),
    .out_valid(seq_out_valid), .out_last(seq_out_last), .out_ready(skid_in_ready)
  );

  cbc_chain_state chain (
    .clk(clk), .load_iv(load_iv), .load_ct(load_ct), .advance_chain(advance_chain),
    .block(payload_block), .out_idx(out_idx), .core_read_data(core_read_data),
    .out_last(seq_out_last), .pt_beat(pt_word), .cur_ct(cur_ct)
  );

  axis_out_skid out_skid (
    .clk(clk), .reset_n(reset_n),
    .in_beat(pt_word), .in_valid(seq_out_valid), .in_ready(skid_in_ready),
    .out_beat(pt_out), .out_valid(pt_tvalid), .out_ready(pt_tready)
  );

  assign pt_tdata = pt_out.data;
  assign pt_tlast = pt_out.last;

endmodule

// File: tests/aes_core_model.sv
`timescale 1ns/1ns

module aes_core_model (
  input  logic                             clk,
  input  logic                             reset_n,
  input  aes_core_regs_pkg::core_bus_req_t core_req,
  output cbc_stream_pkg::word_t            read_data
);

  import aes_core_regs_pkg::*;
  import cbc_stream_pkg::*;

  localparam int INIT_BUSY = 10;
  localparam int NEXT_BUSY = 15;

  word_t      key_reg [BLOCK_WORDS];
  word_t      block_reg [BLOCK_WORDS];
  word_t      result_reg [BLOCK_WORDS];
  logic       ready;
  logic       next_pending;
  logic [4:0] busy_cnt;
  logic       write;

  assign write = core_req.cs && core_req.we;

  // ---------------------------------------------------------
  // ctrl, status and the stand-in cipher
  // ---------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready        <= 1'b1;
      next_pending <= 1'b0;
      busy_cnt     <= '0;
    end else if (write && core_req.address == ADDR_CTRL) begin
      // a held write restarts the busy time every cycle
      ready        <= 1'b0;
      next_pending <= core_req.write_data[CTRL_NEXT_BIT];
      busy_cnt     <= core_req.write_data[CTRL_NEXT_BIT] ? 5'(NEXT_BUSY) : 5'(INIT_BUSY);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 5'd1;
      if (busy_cnt == 5'd1) begin
        ready        <= 1'b1;
        next_pending <= 1'b0;
        if (next_pending) begin
          for (int i = 0; i < BLOCK_WORDS; i++) begin
            result_reg[i] <= block_reg[i] ^ key_reg[i];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write && core_req.address[7:2] == ADDR_KEY0[7:2]) begin
      key_reg[core_req.address[1:0]] <= core_req.write_data;
    end
    if (write && core_req.address[7:2] == ADDR_BLOCK0[7:2]) begin
      block_reg[core_req.address[1:0]] <= core_req.write_data;
    end
  end

  always_comb begin
    read_data = '0;
    if (core_req.address == ADDR_STATUS) begin
      read_data[STATUS_READY_BIT] = ready;
    end else if (core_req.address[7:2] == ADDR_RESULT0[7:2]) begin
      read_data = result_reg[core_req.address[1:0]];
    end
  end

endmodule

// File: tests/aes_cbc_dec_chk.sv
`timescale 1ns/1ns

module aes_cbc_dec_chk (
  input logic                             clk,
  input logic                             reset_n,
  input cbc_stream_pkg::word_t            pt_tdata,
  input logic                             pt_tvalid,
  input logic                             pt_tlast,
  input logic                             pt_tready,
  input logic                             key_tready,
  input logic                             ct_tready,
  input aes_core_regs_pkg::core_bus_req_t core_req
);

  // a stalled plaintext beat stays put until taken
  pt_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
    pt_tvalid && !pt_tready |=> pt_tvalid && $stable(pt_tdata) && $stable(pt_tlast))
    else $error("plaintext beat changed while stalled");

  bus_we_a: assert property (@(posedge clk) disable iff (!reset_n)
    core_req.we |-> core_req.cs)
    else $error("core write strobe without chip select");

  // only one input stream open at a time
  ready_excl_a: assert property (@(posedge clk) disable iff (!reset_n)
    !(key_tready && ct_tready))
    else $error("key and payload streams ready together");

endmodule

// File: tests/tb_aes_cbc_dec.sv
`timescale 1ns/1ns

module tb_aes_cbc_dec;

  import aes_core_regs_pkg::*;
  import cbc_stream_pkg::*;

  // about a dozen blocks of under 100 cycles each plus a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic          clk;
  logic          reset_n;
  word_t         key_tdata;
  logic          key_tvalid;
  logic          key_tready;
  word_t         ct_tdata;
  logic          ct_tvalid;
  logic          ct_tlast;
  logic          ct_tready;
  word_t         pt_tdata;
  logic          pt_tvalid;
  logic          pt_tlast;
  logic          pt_tready;
  core_bus_req_t core_req;
  word_t         core_read_data;

  word_t key_words [BLOCK_WORDS];
  word_t pt_q [$];
  logic  last_q [$];
  logic  stall_pt;
  logic  gaps;
  int    cycles;

  aes_cbc_dec_top #(.KE_WAIT_CYCLES(20), .DEC_WAIT_CYCLES(20)) dut (
    .clk(clk), .reset_n(reset_n),
    .key_tdata(key_tdata), .key_tvalid(key_tvalid), .key_tready(key_tready),
    .ct_tdata(ct_tdata), .ct_tvalid(ct_tvalid), .ct_tlast(ct_tlast), .ct_tready(ct_tready),
    .pt_tdata(pt_tdata), .pt_tvalid(pt_tvalid), .pt_tlast(pt_tlast), .pt_tready(pt_tready),
    .core_req(core_req), .core_read_data(core_read_data)
  );

  aes_core_model core (
    .clk(clk), .reset_n(reset_n), .core_req(core_req), .read_data(core_read_data)
  );

  bind aes_cbc_dec_top aes_cbc_dec_chk chk (
    .clk(clk), .reset_n(reset_n), .pt_tdata(pt_tdata), .pt_tvalid(pt_tvalid),
    .pt_tlast(pt_tlast), .pt_tready(pt_tready), .key_tready(key_tready),
    .ct_tready(ct_tready), .core_req(core_req)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: plaintext still missing after %0d cycles", cycles);
      $display("test failed");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // plaintext sink taking a beat on valid and ready
  always @(negedge clk) begin
    if (stall_pt) begin
      pt_tready = (($urandom % 3) != 0);
    end else begin
      pt_tready = 1'b1;
    end
    if (pt_tvalid && pt_tready) begin
      pt_q.push_back(pt_tdata);
      last_q.push_back(pt_tlast);
    end
  end

  // ---------------------------------------------------------
  // helpers
  // ---------------------------------------------------------
  task automatic check_equal(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "simulation stopped at first error");
    end
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
  endtask

  task automatic send_word(input logic to_key, input word_t data, input logic last);
    logic accepted;
    if (gaps) begin
      repeat ($urandom % 4) @(negedge clk);
    end
    if (to_key) begin
      key_tdata  = data;
      key_tvalid = 1'b1;
    end else begin
      ct_tdata  = data;
      ct_tlast  = last;
      ct_tvalid = 1'b1;
    end
    accepted = 1'b0;
    while (!accepted) begin
      accepted = to_key ? key_tready : ct_tready;
      @(negedge clk);
    end
    key_tvalid = 1'b0;
    ct_tvalid  = 1'b0;
    ct_tlast   = 1'b0;
  endtask

  task automatic load_key();
    foreach (key_words[i]) begin
      key_words[i] = $urandom;
      send_word(1'b1, key_words[i], 1'b0);
    end
  endtask

  // one payload of random iv and ciphertext checked word by word
  task automatic run_payload(input string name, input int blocks);
    word_t iv [BLOCK_WORDS];
    word_t prev [BLOCK_WORDS];
    word_t ct [$];
    int    n;
    n = blocks * BLOCK_WORDS;
    foreach (iv[i]) begin
      iv[i] = $urandom;
    end
    for (int i = 0; i < n; i++) begin
      ct.push_back($urandom);
    end
    pt_q.delete();
    last_q.delete();
    foreach (iv[i]) begin
      send_word(1'b0, iv[i], 1'b0);
    end
    foreach (ct[i]) begin
      send_word(1'b0, ct[i], i == n - 1);
    end
    while (pt_q.size() < n) begin
      @(negedge clk);
    end
    // room for a stray extra word
    repeat (20) @(negedge clk);
    check_equal({name, ": word count"}, word_t'(pt_q.size()), word_t'(n));
    prev = iv;
    for (int i = 0; i < n; i++) begin
      check_equal({name, ": data"}, pt_q[i],
                  ct[i] ^ key_words[i % BLOCK_WORDS] ^ prev[i % BLOCK_WORDS]);
      check_equal({name, ": last"}, word_t'(last_q[i]), word_t'(i == n - 1));
      if (i % BLOCK_WORDS == BLOCK_WORDS - 1) begin
        for (int j = 0; j < BLOCK_WORDS; j++) begin
          prev[j] = ct[i - (BLOCK_WORDS - 1) + j];
        end
      end
    end
  endtask

  // ---------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------
  task automatic test_single_block();
    run_payload("single block", 1);
  endtask

  task automatic test_three_blocks();
    run_payload("three blocks", 3);
  endtask

  task automatic test_new_iv();
    run_payload("new iv same key", 2);
  endtask

  task automatic test_back_pressure();
    stall_pt = 1'b1;
    run_payload("back-pressure", 3);
    stall_pt = 1'b0;
  endtask

  task automatic test_input_gaps();
    gaps = 1'b1;
    apply_reset();
    load_key();
    run_payload("input gaps", 2);
    gaps = 1'b0;
  endtask

  initial begin
    void'($urandom(73));
    cycles     = 0;
    key_tdata  = '0;
    key_tvalid = 1'b0;
    ct_tdata   = '0;
    ct_tvalid  = 1'b0;
    ct_tlast   = 1'b0;
    pt_tready  = 1'b0;
    stall_pt   = 1'b0;
    gaps       = 1'b0;
    apply_reset();
    load_key();
    test_single_block();
    test_three_blocks();
    test_new_iv();
    test_back_pressure();
    test_input_gaps();
    $display("test passed");
    $finish;
  end

endmodule

// File: vlog.f
design/aes_core_regs_pkg.sv
design/cbc_stream_pkg.sv
design/axis_block_gather.sv
design/cbc_chain_state.sv
design/cbc_dec_sequencer.sv
design/axis_out_skid.sv
design/aes_cbc_dec_top.sv
tests/aes_core_model.sv
tests/aes_cbc_dec_chk.sv
tests/tb_aes_cbc_dec.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes_cbc_dec
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation did not finish, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
